// ==== verilog.f ====
src/l15_adapter_pkg.sv
src/icache_fill_buffer.sv
src/l15_req_arbiter.sv
src/l15_req_encoder.sv
src/l15_rtrn_decoder.sv
src/l15_adapter.sv
verif/tb_clock_gen.sv
verif/l15_model.sv
verif/l15_adapter_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the l15_adapter testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module l15_adapter_tb \
  -f verilog.f \
  -o l15_adapter_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/l15_adapter_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi

echo "Simulation finished with status 0"
exit 0

// ==== verif/l15_adapter_tb.sv ====
`default_nettype none

module l15_adapter_tb;

  import l15_adapter_pkg::*;

  localparam int MAX_CYCLES = 4000;
  localparam int NUM_MIXED  = 30;

  // Request sizes in log2 bytes, a fill is one 32-byte line
  localparam logic [2:0] FILL_SIZE = 3'd5;
  localparam logic [2:0] RD_SIZE   = 3'd4;
  localparam logic [2:0] WR_SIZE   = 3'd3;

  logic clk_i;
  logic reset_i;
  logic icache_fill_valid_i, icache_fill_ready_o, icache_fill_resp_valid_o;
  paddr_t icache_fill_paddr_i;
  icache_line_t icache_fill_resp_data_o;
  logic dcache_read_valid_i, dcache_read_ready_o;
  logic dcache_read_resp_valid_o, dcache_read_resp_ready_i;
  mem_req_t dcache_read_req_i, dcache_write_req_i;
  dcache_line_t dcache_read_resp_data_o;
  logic dcache_write_valid_i, dcache_write_ready_o, dcache_write_data_valid_i;
  logic dcache_write_resp_valid_o, dcache_write_resp_ready_i;
  mem_wdata_t dcache_write_data_i;
  l15_req_t l15_req_o;
  l15_rtrn_t l15_rtrn_i;

  // Reference state of each source
  paddr_t fill_addr, rd_addr, wr_addr;
  wdata_t wr_data;
  be_t wr_be;
  logic fill_busy = 1'b0, rd_busy = 1'b0, wr_busy = 1'b0;
  logic fill_pending, req_valid_q, rst_q = 1'b0;
  logic [NUM_SRC-1:0] req_vec_q;
  src_id_t rr_ptr;
  logic rd_hold, wr_hold;
  dcache_line_t rd_hold_data;
  int cycles = 0;

  tb_clock_gen u_clock_gen (.clk_o(clk_i));

  l15_adapter u_l15_adapter (.*);

  l15_model u_l15_model (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .l15_req_i  (l15_req_o),
    .l15_rtrn_o (l15_rtrn_i)
  );

  task automatic report_mismatch(input string name, input logic [255:0] exp,
                                 input logic [255:0] act);
    $display("Mismatch %s: expected %h, actual %h", name, exp, act);
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1);
  endtask

  function automatic l15_data_t addr_pattern(input paddr_t addr);
    l15_data_t d;
    for (int i = 0; i < 8; i++) begin
      d[i*32 +: 32] = addr[31:0] ^ 32'(i);
    end
    return d;
  endfunction

  function automatic paddr_t random_addr();
    return paddr_t'({$urandom(), $urandom()});
  endfunction

  always @(posedge clk_i) begin : monitor
    src_id_t win;
    logic    found;
    int      idx;
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      abort_run("Timeout, the tests did not finish within the cycle limit");
    end
    if ((reset_i && cycles > 1) || rst_q) begin
      assert (!icache_fill_resp_valid_o && !dcache_read_resp_valid_o &&
              !dcache_write_resp_valid_o && !l15_req_o.valid)
        else abort_run("A valid output was high during or just after reset");
    end
    rst_q = reset_i;
    if (reset_i) begin
      rr_ptr       = SRC_ICACHE;
      req_valid_q  = 1'b0;
      req_vec_q    = '0;
      fill_pending = 1'b0;
      rd_hold      = 1'b0;
      wr_hold      = 1'b0;
    end else begin
      // New L1.5 request, granted from the requesters seen one edge earlier
      if (l15_req_o.valid && !req_valid_q) begin
        found = 1'b0;
        win   = rr_ptr;
        for (int i = 0; i < NUM_SRC; i++) begin
          idx = (int'(rr_ptr) + i) % NUM_SRC;
          if (!found && req_vec_q[idx]) begin
            found = 1'b1;
            win   = src_id_t'(idx);
          end
        end
        assert (found) else abort_run("L1.5 request issued with no source requesting");
        assert (l15_req_o.threadid == win)
          else report_mismatch("round robin thread id", 256'(win), 256'(l15_req_o.threadid));
        rr_ptr = (win == SRC_DWRITE) ? SRC_ICACHE : src_id_t'(win + 2'd1);
        case (win)
          SRC_ICACHE: begin
            assert (l15_req_o.rqtype == IFILL && l15_req_o.address == fill_addr &&
                    l15_req_o.size == FILL_SIZE)
              else report_mismatch("ifill request",
                256'({IFILL, fill_addr, FILL_SIZE}),
                256'({l15_req_o.rqtype, l15_req_o.address, l15_req_o.size}));
            fill_pending = 1'b0;
          end
          SRC_DREAD: begin
            assert (l15_req_o.rqtype == LOAD && l15_req_o.address == rd_addr &&
                    l15_req_o.size == RD_SIZE)
              else report_mismatch("load request",
                256'({LOAD, rd_addr, RD_SIZE}),
                256'({l15_req_o.rqtype, l15_req_o.address, l15_req_o.size}));
          end
          default: begin
            assert (l15_req_o.rqtype == STORE && l15_req_o.address == wr_addr &&
                    l15_req_o.size == WR_SIZE &&
                    l15_req_o.data == wr_data && l15_req_o.be == wr_be)
              else report_mismatch("store request",
                256'({STORE, wr_addr, WR_SIZE, wr_data, wr_be}),
                256'({l15_req_o.rqtype, l15_req_o.address, l15_req_o.size,
                      l15_req_o.data, l15_req_o.be}));
          end
        endcase
      end
      req_valid_q = l15_req_o.valid;
      req_vec_q   = {dcache_write_valid_i & dcache_write_data_valid_i,
                     dcache_read_valid_i, fill_pending};
      if (icache_fill_valid_i && icache_fill_ready_o) begin
        fill_pending = 1'b1;
      end
      assert (!(dcache_write_ready_o && !dcache_write_data_valid_i))
        else abort_run("Write accepted while its data beat was invalid");

      if (icache_fill_resp_valid_o) begin
        assert (fill_busy) else abort_run("Unexpected instruction fill response");
        assert (icache_fill_resp_data_o == addr_pattern(fill_addr))
          else report_mismatch("ifill data", addr_pattern(fill_addr), icache_fill_resp_data_o);
        fill_busy = 1'b0;
      end

      if (rd_hold) begin
        assert (dcache_read_resp_valid_o && dcache_read_resp_data_o == rd_hold_data)
          else report_mismatch("read response hold", 256'(rd_hold_data),
                               256'(dcache_read_resp_data_o));
      end
      if (dcache_read_resp_valid_o) begin
        assert (rd_busy) else abort_run("Unexpected data read response");
        assert (dcache_read_resp_data_o == dcache_line_t'(addr_pattern(rd_addr)))
          else report_mismatch("read data", 256'(dcache_line_t'(addr_pattern(rd_addr))),
                               256'(dcache_read_resp_data_o));
        if (dcache_read_resp_ready_i) begin
          rd_busy = 1'b0;
        end
      end
      rd_hold      = dcache_read_resp_valid_o && !dcache_read_resp_ready_i;
      rd_hold_data = dcache_read_resp_data_o;

      if (wr_hold) begin
        assert (dcache_write_resp_valid_o)
          else report_mismatch("write response hold", 256'(1), 256'(0));
      end
      if (dcache_write_resp_valid_o) begin
        assert (wr_busy) else abort_run("Unexpected data write response");
        if (dcache_write_resp_ready_i) begin
          wr_busy = 1'b0;
        end
      end
      wr_hold = dcache_write_resp_valid_o && !dcache_write_resp_ready_i;
    end
  end

  // Random back-pressure on both data cache responses
  always @(posedge clk_i) begin
    dcache_read_resp_ready_i  <= ($urandom_range(2, 0) != 0);
    dcache_write_resp_ready_i <= ($urandom_range(2, 0) != 0);
  end

  task automatic fill_line(input paddr_t addr);
    fill_addr = addr;
    fill_busy = 1'b1;
    icache_fill_valid_i <= 1'b1;
    icache_fill_paddr_i <= addr;
    @(posedge clk_i);
    while (!icache_fill_ready_o) @(posedge clk_i);
    icache_fill_valid_i <= 1'b0;
    while (fill_busy) @(posedge clk_i);
  endtask

  task automatic read_line(input paddr_t addr);
    rd_addr = addr;
    rd_busy = 1'b1;
    dcache_read_valid_i <= 1'b1;
    dcache_read_req_i   <= '{addr: addr, size: RD_SIZE};
    @(posedge clk_i);
    while (!dcache_read_ready_o) @(posedge clk_i);
    dcache_read_valid_i <= 1'b0;
    while (rd_busy) @(posedge clk_i);
  endtask

  task automatic write_word(input paddr_t addr);
    int gap;
    wr_addr = addr;
    wr_data = wdata_t'({$urandom(), $urandom()});
    wr_be   = be_t'($urandom());
    wr_busy = 1'b1;
    gap     = int'($urandom_range(2, 0));
    dcache_write_valid_i <= 1'b1;
    dcache_write_req_i   <= '{addr: addr, size: WR_SIZE};
    // Data beat may trail the request beat
    repeat (gap) @(posedge clk_i);
    dcache_write_data_valid_i <= 1'b1;
    dcache_write_data_i       <= '{data: wr_data, be: wr_be};
    @(posedge clk_i);
    while (!dcache_write_ready_o) @(posedge clk_i);
    dcache_write_valid_i      <= 1'b0;
    dcache_write_data_valid_i <= 1'b0;
    while (wr_busy) @(posedge clk_i);
  endtask

  initial begin
    void'($urandom(32'he862));
    reset_i                   = 1'b1;
    icache_fill_valid_i       = 1'b0;
    icache_fill_paddr_i       = '0;
    dcache_read_valid_i       = 1'b0;
    dcache_read_req_i         = '0;
    dcache_read_resp_ready_i  = 1'b0;
    dcache_write_valid_i      = 1'b0;
    dcache_write_req_i        = '0;
    dcache_write_data_valid_i = 1'b0;
    dcache_write_data_i       = '0;
    dcache_write_resp_ready_i = 1'b0;
    repeat (2) @(posedge clk_i);
    reset_i <= 1'b0;
    @(posedge clk_i);
    fill_line(random_addr());
    read_line(random_addr());
    write_word(random_addr());
    // All three sources together
    fork
      repeat (NUM_MIXED) fill_line(random_addr());
      repeat (NUM_MIXED) read_line(random_addr());
      repeat (NUM_MIXED) write_word(random_addr());
    join
    repeat (4) @(posedge clk_i);
    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verif/l15_model.sv ====
`default_nettype none

module l15_model (
  input  wire logic                       clk_i,
  input  wire logic                       reset_i,
  input  wire l15_adapter_pkg::l15_req_t  l15_req_i,
  output l15_adapter_pkg::l15_rtrn_t      l15_rtrn_o
);

  import l15_adapter_pkg::*;

  l15_req_t  pend_q[$];
  l15_rtrn_t rtrn_q;
  logic      hdr_ack_q;
  int        delay = -1;

  // Each 32-bit word is the low address word XOR its index
  function automatic l15_data_t line_pattern(input paddr_t addr);
    l15_data_t d;
    for (int i = 0; i < L15_DATA_W / 32; i++) begin
      d[i*32 +: 32] = addr[31:0] ^ 32'(i);
    end
    return d;
  endfunction

  always @(posedge clk_i) begin : l15_behaviour
    int       idx;
    l15_req_t e;
    if (reset_i) begin
      hdr_ack_q    <= 1'b0;
      rtrn_q.valid <= 1'b0;
      delay = -1;
      pend_q.delete();
    end else begin
      hdr_ack_q <= 1'b0;
      // Header ack after 0 to 3 cycles
      if (l15_req_i.valid && !hdr_ack_q) begin
        if (delay < 0) begin
          delay = int'($urandom_range(3, 0));
        end
        if (delay == 0) begin
          hdr_ack_q <= 1'b1;
          pend_q.push_back(l15_req_i);
          delay = -1;
        end else begin
          delay = delay - 1;
        end
      end
      // Return held until the decoder acknowledges it
      if (rtrn_q.valid) begin
        if (l15_req_i.rtrn_ack) begin
          rtrn_q.valid <= 1'b0;
        end
      end else if (pend_q.size() > 0 && $urandom_range(1, 0) == 1) begin
        idx = int'($urandom_range(pend_q.size() - 1, 0));
        e   = pend_q[idx];
        pend_q.delete(idx);
        rtrn_q.valid    <= 1'b1;
        rtrn_q.threadid <= e.threadid;
        rtrn_q.rtntype  <= (e.rqtype == STORE) ? ST_ACK :
                           (e.rqtype == IFILL) ? IFILL_RET : LOAD_RET;
        rtrn_q.data     <= (e.rqtype == STORE) ? '0 : line_pattern(e.address);
      end
    end
  end

  always_comb begin
    l15_rtrn_o            = rtrn_q;
    l15_rtrn_o.header_ack = hdr_ack_q;
  end

endmodule

`default_nettype wire

// ==== verif/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen (
  output logic clk_o
);

  initial clk_o = 1'b0;

  // 40 time unit period
  always #20 clk_o = ~clk_o;

endmodule

`default_nettype wire

// ==== src/l15_adapter.sv ====
`default_nettype none

module l15_adapter (
  input  wire logic                          clk_i,
  input  wire logic                          reset_i,

  // Instruction cache fill
  input  wire logic                          icache_fill_valid_i,
  output logic                               icache_fill_ready_o,
  input  wire l15_adapter_pkg::paddr_t       icache_fill_paddr_i,
  output logic                               icache_fill_resp_valid_o,
  output l15_adapter_pkg::icache_line_t      icache_fill_resp_data_o,

  // Data cache read miss
  input  wire logic                          dcache_read_valid_i,
  output logic                               dcache_read_ready_o,
  input  wire l15_adapter_pkg::mem_req_t     dcache_read_req_i,
  output logic                               dcache_read_resp_valid_o,
  input  wire logic                          dcache_read_resp_ready_i,
  output l15_adapter_pkg::dcache_line_t      dcache_read_resp_data_o,

  // Data cache write buffer
  input  wire logic                          dcache_write_valid_i,
  output logic                               dcache_write_ready_o,
  input  wire l15_adapter_pkg::mem_req_t     dcache_write_req_i,
  input  wire logic                          dcache_write_data_valid_i,
  input  wire l15_adapter_pkg::mem_wdata_t   dcache_write_data_i,
  output logic                               dcache_write_resp_valid_o,
  input  wire logic                          dcache_write_resp_ready_i,

  // L1.5 native interface
  output l15_adapter_pkg::l15_req_t          l15_req_o,
  input  wire l15_adapter_pkg::l15_rtrn_t    l15_rtrn_i
);

  import l15_adapter_pkg::*;

  // Fill buffer to arbiter
  logic       ifill_valid;
  logic       ifill_ready;
  mem_req_t   ifill_req;

  // Arbiter to encoder
  logic       arb_valid;
  logic       arb_ready;
  mem_req_t   arb_req;
  mem_wdata_t arb_wdata;
  src_id_t    arb_src;

  logic       rtrn_ack;
  logic       hdr_ack;

  assign hdr_ack = l15_rtrn_i.header_ack;

  icache_fill_buffer u_icache_fill_buffer (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .fill_valid_i (icache_fill_valid_i),
    .fill_ready_o (icache_fill_ready_o),
    .fill_paddr_i (icache_fill_paddr_i),
    .req_valid_o  (ifill_valid),
    .req_ready_i  (ifill_ready),
    .req_o        (ifill_req)
  );

  l15_req_arbiter u_l15_req_arbiter (
    .clk_i               (clk_i),
    .reset_i             (reset_i),
    .ifill_valid_i       (ifill_valid),
    .ifill_ready_o       (ifill_ready),
    .ifill_req_i         (ifill_req),
    .dread_valid_i       (dcache_read_valid_i),
    .dread_ready_o       (dcache_read_ready_o),
    .dread_req_i         (dcache_read_req_i),
    .dwrite_valid_i      (dcache_write_valid_i),
    .dwrite_ready_o      (dcache_write_ready_o),
    .dwrite_req_i        (dcache_write_req_i),
    .dwrite_data_valid_i (dcache_write_data_valid_i),
    .dwrite_data_i       (dcache_write_data_i),
    .arb_valid_o         (arb_valid),
    .arb_ready_i         (arb_ready),
    .arb_req_o           (arb_req),
    .arb_wdata_o         (arb_wdata),
    .arb_src_o           (arb_src)
  );

  l15_req_encoder u_l15_req_encoder (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .arb_valid_i   (arb_valid),
    .arb_ready_o   (arb_ready),
    .arb_req_i     (arb_req),
    .arb_wdata_i   (arb_wdata),
    .arb_src_i     (arb_src),
    .rtrn_ack_i    (rtrn_ack),
    .l15_req_o     (l15_req_o),
    .l15_hdr_ack_i (hdr_ack)
  );

  l15_rtrn_decoder u_l15_rtrn_decoder (
    .clk_i               (clk_i),
    .reset_i             (reset_i),
    .l15_rtrn_i          (l15_rtrn_i),
    .rtrn_ack_o          (rtrn_ack),
    .ifill_resp_valid_o  (icache_fill_resp_valid_o),
    .ifill_resp_data_o   (icache_fill_resp_data_o),
    .dread_resp_valid_o  (dcache_read_resp_valid_o),
    .dread_resp_ready_i  (dcache_read_resp_ready_i),
    .dread_resp_data_o   (dcache_read_resp_data_o),
    .dwrite_resp_valid_o (dcache_write_resp_valid_o),
    .dwrite_resp_ready_i (dcache_write_resp_ready_i)
  );

endmodule

`default_nettype wire

// ==== src/l15_rtrn_decoder.sv ====
`default_nettype none

module l15_rtrn_decoder (
  input  wire logic                         clk_i,
  input  wire logic                         reset_i,

  // From the L1.5
  input  wire l15_adapter_pkg::l15_rtrn_t   l15_rtrn_i,
  output logic                              rtrn_ack_o,

  // Instruction fill response, no ready
  output logic                              ifill_resp_valid_o,
  output l15_adapter_pkg::icache_line_t     ifill_resp_data_o,

  // Data read response
  output logic                              dread_resp_valid_o,
  input  wire logic                         dread_resp_ready_i,
  output l15_adapter_pkg::dcache_line_t     dread_resp_data_o,

  // Data write response, acknowledge only
  output logic                              dwrite_resp_valid_o,
  input  wire logic                         dwrite_resp_ready_i
);

  import l15_adapter_pkg::*;

  logic      full_q;
  src_resp_t resp_q;
  logic      capture;
  logic      take;
  l15_data_t resp_data;

  // Ack only when there is room, which holds the L1.5 under back-pressure
  assign capture    = l15_rtrn_i.valid & ~full_q;
  assign rtrn_ack_o = capture;

  assign ifill_resp_valid_o  = full_q && (resp_q.threadid == SRC_ICACHE);
  assign dread_resp_valid_o  = full_q && (resp_q.threadid == SRC_DREAD);
  assign dwrite_resp_valid_o = full_q && (resp_q.threadid == SRC_DWRITE);

  // Fill response is consumed in its first cycle
  assign take = ifill_resp_valid_o
              | (dread_resp_valid_o & dread_resp_ready_i)
              | (dwrite_resp_valid_o & dwrite_resp_ready_i);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      full_q <= 1'b0;
    end else if (capture) begin
      full_q <= 1'b1;
    end else if (take) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (capture) begin
      resp_q.threadid <= l15_rtrn_i.threadid;
      resp_q.rtntype  <= l15_rtrn_i.rtntype;
      resp_q.data     <= l15_rtrn_i.data;
    end
  end

  // Store acks have no payload
  assign resp_data = (resp_q.rtntype == ST_ACK) ? '0 : resp_q.data;

  assign ifill_resp_data_o = resp_data[ICACHE_LINE_W-1:0];
  assign dread_resp_data_o = resp_data[DCACHE_LINE_W-1:0];

endmodule

`default_nettype wire

// ==== src/l15_req_encoder.sv ====
`default_nettype none

module l15_req_encoder (
  input  wire logic                        clk_i,
  input  wire logic                        reset_i,

  // From the arbiter
  input  wire logic                        arb_valid_i,
  output logic                             arb_ready_o,
  input  wire l15_adapter_pkg::mem_req_t   arb_req_i,
  input  wire l15_adapter_pkg::mem_wdata_t arb_wdata_i,
  input  wire l15_adapter_pkg::src_id_t    arb_src_i,

  // Return acknowledge from the decoder
  input  wire logic                        rtrn_ack_i,

  // L1.5 request side
  output l15_adapter_pkg::l15_req_t        l15_req_o,
  input  wire logic                        l15_hdr_ack_i
);

  import l15_adapter_pkg::*;

  logic        valid_q;
  l15_rqtype_e rqtype_d;
  l15_rqtype_e rqtype_q;
  src_id_t     tid_q;
  mem_req_t    req_q;
  mem_wdata_t  wdata_q;
  logic        load;

  // One request in flight toward the L1.5
  assign arb_ready_o = ~valid_q;
  assign load        = arb_valid_i & ~valid_q;

  // Source id decides the L1.5 request type
  always_comb begin
    case (arb_src_i)
      SRC_ICACHE: rqtype_d = IFILL;
      SRC_DWRITE: rqtype_d = STORE;
      default:    rqtype_d = LOAD;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else if (load) begin
      valid_q <= 1'b1;
    end else if (valid_q && l15_hdr_ack_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      rqtype_q <= rqtype_d;
      tid_q    <= arb_src_i;
      req_q    <= arb_req_i;
      wdata_q  <= arb_wdata_i;
    end
  end

  // Held stable until the header is acknowledged
  always_comb begin
    l15_req_o.valid    = valid_q;
    l15_req_o.rqtype   = rqtype_q;
    l15_req_o.threadid = tid_q;
    l15_req_o.address  = req_q.addr;
    l15_req_o.size     = req_q.size;
    l15_req_o.data     = wdata_q.data;
    l15_req_o.be       = wdata_q.be;
    // Return ack rides along independently of the request
    l15_req_o.rtrn_ack = rtrn_ack_i;
  end

endmodule

`default_nettype wire

// ==== src/l15_req_arbiter.sv ====
`default_nettype none

module l15_req_arbiter (
  input  wire logic                        clk_i,
  input  wire logic                        reset_i,

  // Instruction fill source
  input  wire logic                        ifill_valid_i,
  output logic                             ifill_ready_o,
  input  wire l15_adapter_pkg::mem_req_t   ifill_req_i,

  // Data read source
  input  wire logic                        dread_valid_i,
  output logic                             dread_ready_o,
  input  wire l15_adapter_pkg::mem_req_t   dread_req_i,

  // Data write source, request and data beats
  input  wire logic                        dwrite_valid_i,
  output logic                             dwrite_ready_o,
  input  wire l15_adapter_pkg::mem_req_t   dwrite_req_i,
  input  wire logic                        dwrite_data_valid_i,
  input  wire l15_adapter_pkg::mem_wdata_t dwrite_data_i,

  // Toward the encoder
  output logic                             arb_valid_o,
  input  wire logic                        arb_ready_i,
  output l15_adapter_pkg::mem_req_t        arb_req_o,
  output l15_adapter_pkg::mem_wdata_t      arb_wdata_o,
  output l15_adapter_pkg::src_id_t         arb_src_o
);

  import l15_adapter_pkg::*;

  logic [NUM_SRC-1:0] req_vec;
  src_id_t            ptr_q;
  src_id_t            win;
  logic               found;
  logic               xfer;

  // A write only counts once both of its beats are there
  assign req_vec[SRC_ICACHE] = ifill_valid_i;
  assign req_vec[SRC_DREAD]  = dread_valid_i;
  assign req_vec[SRC_DWRITE] = dwrite_valid_i & dwrite_data_valid_i;

  // First requester at or after the pointer
  always_comb begin : pick_winner
    int idx;
    found = 1'b0;
    win   = ptr_q;
    for (int i = 0; i < NUM_SRC; i++) begin
      idx = int'(ptr_q) + i;
      if (idx >= NUM_SRC) begin
        idx = idx - NUM_SRC;
      end
      if (!found && req_vec[idx]) begin
        found = 1'b1;
        win   = src_id_t'(idx);
      end
    end
  end

  assign arb_valid_o = found;
  assign arb_src_o   = win;
  assign xfer        = found & arb_ready_i;

  assign ifill_ready_o  = xfer && (win == SRC_ICACHE);
  assign dread_ready_o  = xfer && (win == SRC_DREAD);
  assign dwrite_ready_o = xfer && (win == SRC_DWRITE);

  always_comb begin
    case (win)
      SRC_ICACHE: arb_req_o = ifill_req_i;
      SRC_DREAD:  arb_req_o = dread_req_i;
      default:    arb_req_o = dwrite_req_i;
    endcase
  end

  // Reads carry no data
  assign arb_wdata_o = (win == SRC_DWRITE) ? dwrite_data_i : '0;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ptr_q <= SRC_ICACHE;
    end else if (xfer) begin
      ptr_q <= (win == src_id_t'(NUM_SRC - 1)) ? SRC_ICACHE : src_id_t'(win + 1'b1);
    end
  end

endmodule

`default_nettype wire

// ==== src/icache_fill_buffer.sv ====
`default_nettype none

module icache_fill_buffer (
  input  wire logic                      clk_i,
  input  wire logic                      reset_i,

  // From the instruction cache
  input  wire logic                      fill_valid_i,
  output logic                           fill_ready_o,
  input  wire l15_adapter_pkg::paddr_t   fill_paddr_i,

  // Toward the arbiter
  output logic                           req_valid_o,
  input  wire logic                      req_ready_i,
  output l15_adapter_pkg::mem_req_t      req_o
);

  import l15_adapter_pkg::*;

  logic   full_q;
  paddr_t paddr_q;
  logic   push;

  // Only accept while empty, so the held entry never changes under a stall
  assign push         = fill_valid_i & ~full_q;
  assign fill_ready_o = ~full_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      full_q <= 1'b0;
    end else if (push) begin
      full_q <= 1'b1;
    end else if (req_ready_i) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      paddr_q <= fill_paddr_i;
    end
  end

  assign req_valid_o = full_q;
  assign req_o.addr  = paddr_q;
  assign req_o.size  = ICACHE_REQ_SIZE;

endmodule

`default_nettype wire

// ==== src/l15_adapter_pkg.sv ====
`default_nettype none

package l15_adapter_pkg;

  // Widths
  localparam int PADDR_W       = 40;
  localparam int ICACHE_LINE_W = 256;
  localparam int DCACHE_LINE_W = 128;
  localparam int WDATA_W       = 64;
  localparam int L15_DATA_W    = 256;
  localparam int BE_W          = WDATA_W / 8;

  // Request sources
  localparam int NUM_SRC  = 3;
  localparam int SRC_ID_W = 2;

  typedef logic [PADDR_W-1:0]       paddr_t;
  typedef logic [SRC_ID_W-1:0]      src_id_t;
  typedef logic [ICACHE_LINE_W-1:0] icache_line_t;
  typedef logic [DCACHE_LINE_W-1:0] dcache_line_t;
  typedef logic [WDATA_W-1:0]       wdata_t;
  typedef logic [L15_DATA_W-1:0]    l15_data_t;
  typedef logic [BE_W-1:0]          be_t;

  localparam src_id_t SRC_ICACHE = 2'd0;
  localparam src_id_t SRC_DREAD  = 2'd1;
  localparam src_id_t SRC_DWRITE = 2'd2;

  // Fill size in log2 bytes, one full instruction line
  localparam logic [2:0] ICACHE_REQ_SIZE = 3'($clog2(ICACHE_LINE_W / 8));

  typedef enum logic [1:0] {
    LOAD  = 2'd0,
    IFILL = 2'd1,
    STORE = 2'd2
  } l15_rqtype_e;

  typedef enum logic [1:0] {
    LOAD_RET  = 2'd0,
    IFILL_RET = 2'd1,
    ST_ACK    = 2'd2
  } l15_rtntype_e;

  typedef struct packed {
    paddr_t     addr;
    logic [2:0] size;
  } mem_req_t;

  typedef struct packed {
    wdata_t data;
    be_t    be;
  } mem_wdata_t;

  typedef struct packed {
    logic        valid;
    l15_rqtype_e rqtype;
    src_id_t     threadid;
    paddr_t      address;
    logic [2:0]  size;
    wdata_t      data;
    be_t         be;
    logic        rtrn_ack;
  } l15_req_t;

  typedef struct packed {
    logic         valid;
    l15_rtntype_e rtntype;
    src_id_t      threadid;
    l15_data_t    data;
    logic         header_ack;
  } l15_rtrn_t;

  // Registered return inside the decoder
  typedef struct packed {
    src_id_t      threadid;
    l15_rtntype_e rtntype;
    l15_data_t    data;
  } src_resp_t;

endpackage

`default_nettype wire
